// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0]  bus_id_t;

  // transaction ids on the shared read bus
  localparam bus_id_t id_fetch = 4'd1;
  localparam bus_id_t id_data  = 4'd2;

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    addr_t pc;
    inst_t instr;
  } fetch_rsp_t;

  typedef struct packed {
    addr_t   addr;
    bus_id_t id;
    logic    burst; // two beats when set
  } bus_req_t;

  typedef struct packed {
    beat_t   data;
    bus_id_t id;
    logic    last;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_gen
  import fetch_pkg::*;
#(
  parameter addr_t reset_pc = 64'h8000_0000
) (
  input  wire logic       clk,
  input  wire logic       rst_n,

  input  wire logic       redirect,
  input  wire addr_t      redirect_pc,

  output logic            req_valid,
  input  wire logic       req_ready,
  output fetch_req_t      req
);

  localparam addr_t step = 64'd4;

  addr_t pc_q;
  logic  valid_q;
  logic  taken;

  assign taken = valid_q && req_ready;

  // valid comes up one cycle after reset and then stays up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= reset_pc;
    end else if (redirect) begin
      pc_q <= redirect_pc; // redirect wins over a same-cycle transfer
    end else if (taken) begin
      pc_q <= pc_q + step;
    end
  end

  assign req_valid = valid_q;
  assign req       = '{addr: pc_q};

endmodule

`default_nettype wire

// ==== logic/icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache
  import fetch_pkg::*;
#(
  parameter int line_count = 16
) (
  input  wire logic       clk,
  input  wire logic       rst_n,

  input  wire logic       redirect,
  input  wire logic       fence_i,

  input  wire logic       req_valid,
  output logic            req_ready,
  input  wire fetch_req_t req,

  output logic            inst_valid,
  input  wire logic       inst_ready,
  output fetch_rsp_t      inst,

  output logic            refill_valid,
  input  wire logic       refill_ready,
  output bus_req_t        refill_req,

  input  wire logic       refill_rsp_valid,
  input  wire bus_rsp_t   refill_rsp
);

  localparam int index_w = $clog2(line_count);
  localparam int tag_w   = 64 - 4 - index_w; // 16 byte lines

  typedef logic [index_w-1:0] index_t;
  typedef logic [tag_w-1:0]   tag_t;

  typedef enum logic [1:0] {
    s_idle,
    s_req,
    s_wait,
    s_deliver
  } state_t;

  state_t state;

  tag_t                  tag_mem  [line_count];
  beat_t [1:0]           data_mem [line_count];
  logic [line_count-1:0] valid_bits;

  addr_t  miss_pc;
  logic   beat_cnt;
  logic   killed;   // redirect seen while the miss was open
  logic   fenced;   // fence seen while the refill was open

  index_t req_index;
  tag_t   req_tag;
  index_t miss_index;
  inst_t  hit_word;
  inst_t  fill_word;
  logic   hit;
  logic   out_free;
  logic   accept;
  logic   load_hit;
  logic   load_fill;
  logic   beat_in;
  logic   fill_done;

  // little endian, beat by pc[3], half by pc[2]
  function automatic inst_t pick_word(input beat_t [1:0] line, input logic [1:0] sel);
    beat_t b;
    b = line[sel[1]];
    return sel[0] ? b[63:32] : b[31:0];
  endfunction

  assign req_index  = req.addr[4 +: index_w];
  assign req_tag    = req.addr[63 -: tag_w];
  assign miss_index = miss_pc[4 +: index_w];

  assign hit       = valid_bits[req_index] && (tag_mem[req_index] == req_tag);
  assign hit_word  = pick_word(data_mem[req_index], req.addr[3:2]);
  assign fill_word = pick_word(data_mem[miss_index], miss_pc[3:2]);

  assign out_free  = !inst_valid || inst_ready;
  assign req_ready = (state == s_idle) && out_free && !redirect && !fence_i;
  assign accept    = req_valid && req_ready;
  assign load_hit  = accept && hit;
  assign load_fill = (state == s_deliver) && out_free && !killed && !redirect;

  assign beat_in   = (state == s_wait) && refill_rsp_valid && (refill_rsp.id == id_fetch);
  assign fill_done = beat_in && refill_rsp.last;

  assign refill_valid = (state == s_req);
  assign refill_req   = '{addr: {miss_pc[63:4], 4'b0000}, id: id_fetch, burst: 1'b1};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= s_idle;
      beat_cnt <= 1'b0;
      killed   <= 1'b0;
      fenced   <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (accept && !hit) begin
            state  <= s_req;
            killed <= 1'b0;
            fenced <= 1'b0;
          end
        end
        s_req: begin
          if (refill_ready) begin
            state    <= s_wait;
            beat_cnt <= 1'b0;
          end
        end
        s_wait: begin
          if (beat_in) begin
            beat_cnt <= !beat_cnt;
            if (refill_rsp.last) state <= s_deliver;
          end
        end
        s_deliver: begin
          if (killed || redirect || out_free) state <= s_idle;
        end
        default: state <= s_idle;
      endcase

      if (redirect && state != s_idle) killed <= 1'b1;
      if (fence_i && state != s_idle) fenced <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !hit) miss_pc <= req.addr;
  end

  // refill beats land in order, tag written with the last one
  always_ff @(posedge clk) begin
    if (beat_in) data_mem[miss_index][beat_cnt] <= refill_rsp.data;
    if (fill_done) tag_mem[miss_index] <= miss_pc[63 -: tag_w];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
    end else if (fence_i) begin
      valid_bits <= '0;
    end else if (fill_done && !fenced) begin
      valid_bits[miss_index] <= 1'b1;
    end
  end

  // output register, flushed by redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid <= 1'b0;
    end else if (redirect) begin
      inst_valid <= 1'b0;
    end else if (load_hit || load_fill) begin
      inst_valid <= 1'b1;
    end else if (inst_ready) begin
      inst_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_hit) begin
      inst <= '{pc: req.addr, instr: hit_word};
    end else if (load_fill) begin
      inst <= '{pc: miss_pc, instr: fill_word};
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
  import fetch_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire logic     refill_valid,
  output logic          refill_ready,
  input  wire bus_req_t refill_req,

  output logic          refill_rsp_valid,
  output bus_rsp_t      refill_rsp,

  input  wire logic     data_valid,
  output logic          data_ready,
  input  wire bus_req_t data_req,

  output logic          data_rsp_valid,
  output bus_rsp_t      data_rsp,

  output logic          bus_valid,
  input  wire logic     bus_ready,
  output bus_req_t      bus_req,

  input  wire logic     bus_rsp_valid,
  input  wire bus_rsp_t bus_rsp
);

  logic busy; // one transaction in flight, from grant to last beat
  logic grant_data;
  logic grant_refill;
  logic done;

  // data side has priority
  assign data_ready   = !busy;
  assign refill_ready = !busy && !data_valid;
  assign grant_data   = data_valid && data_ready;
  assign grant_refill = refill_valid && refill_ready;

  assign done = busy && bus_rsp_valid && bus_rsp.last && (bus_rsp.id == bus_req.id);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      bus_valid <= 1'b0;
    end else begin
      if (grant_data || grant_refill) begin
        busy      <= 1'b1;
        bus_valid <= 1'b1;
      end else begin
        if (bus_valid && bus_ready) bus_valid <= 1'b0;
        if (done) busy <= 1'b0;
      end
    end
  end

  // request held here until the bus takes it
  always_ff @(posedge clk) begin
    if (grant_data) begin
      bus_req <= '{addr: data_req.addr, id: id_data, burst: data_req.burst};
    end else if (grant_refill) begin
      bus_req <= '{addr: refill_req.addr, id: id_fetch, burst: refill_req.burst};
    end
  end

  // steer beats by id
  assign refill_rsp_valid = busy && bus_rsp_valid && (bus_rsp.id == id_fetch);
  assign data_rsp_valid   = busy && bus_rsp_valid && (bus_rsp.id == id_data);
  assign refill_rsp       = bus_rsp;
  assign data_rsp         = bus_rsp;

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top
  import fetch_pkg::*;
#(
  parameter addr_t reset_pc   = 64'h8000_0000,
  parameter int    line_count = 16
) (
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire logic     redirect,
  input  wire addr_t    redirect_pc,
  input  wire logic     fence_i,

  output logic          inst_valid,
  input  wire logic     inst_ready,
  output fetch_rsp_t    inst,

  input  wire logic     data_valid,
  output logic          data_ready,
  input  wire bus_req_t data_req,
  output logic          data_rsp_valid,
  output bus_rsp_t      data_rsp,

  output logic          bus_valid,
  input  wire logic     bus_ready,
  output bus_req_t      bus_req,
  input  wire logic     bus_rsp_valid,
  input  wire bus_rsp_t bus_rsp
);

  logic       fetch_valid;
  logic       fetch_ready;
  fetch_req_t fetch_req;

  logic       refill_valid;
  logic       refill_ready;
  bus_req_t   refill_req;
  logic       refill_rsp_valid;
  bus_rsp_t   refill_rsp;

  pc_gen #(
    .reset_pc (reset_pc)
  ) u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .req_valid   (fetch_valid),
    .req_ready   (fetch_ready),
    .req         (fetch_req)
  );

  icache #(
    .line_count (line_count)
  ) u_icache (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect         (redirect),
    .fence_i          (fence_i),
    .req_valid        (fetch_valid),
    .req_ready        (fetch_ready),
    .req              (fetch_req),
    .inst_valid       (inst_valid),
    .inst_ready       (inst_ready),
    .inst             (inst),
    .refill_valid     (refill_valid),
    .refill_ready     (refill_ready),
    .refill_req       (refill_req),
    .refill_rsp_valid (refill_rsp_valid),
    .refill_rsp       (refill_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .refill_valid     (refill_valid),
    .refill_ready     (refill_ready),
    .refill_req       (refill_req),
    .refill_rsp_valid (refill_rsp_valid),
    .refill_rsp       (refill_rsp),
    .data_valid       (data_valid),
    .data_ready       (data_ready),
    .data_req         (data_req),
    .data_rsp_valid   (data_rsp_valid),
    .data_rsp         (data_rsp),
    .bus_valid        (bus_valid),
    .bus_ready        (bus_ready),
    .bus_req          (bus_req),
    .bus_rsp_valid    (bus_rsp_valid),
    .bus_rsp          (bus_rsp)
  );

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_model
  import fetch_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire logic     bus_valid,
  output logic          bus_ready,
  input  wire bus_req_t bus_req,

  output logic          bus_rsp_valid,
  output bus_rsp_t      bus_rsp
);

  logic [31:0] rnd;
  logic [1:0]  delay;
  logic        counting;
  logic        sending;
  logic        beat_idx;
  bus_req_t    cur;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // same word rule as the testbench top
  function automatic inst_t word_at(input addr_t a);
    return (a[31:0] * 32'h9e37_79b1) ^ a[63:32] ^ 32'h3c5a_96e1;
  endfunction

  function automatic beat_t beat_at(input addr_t a);
    addr_t base;
    base = {a[63:3], 3'b000};
    return {word_at(base + 64'd4), word_at(base)};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rnd           <= 32'd20;
      delay         <= 2'd0;
      counting      <= 1'b0;
      sending       <= 1'b0;
      beat_idx      <= 1'b0;
      cur           <= '0;
      bus_ready     <= 1'b0;
      bus_rsp_valid <= 1'b0;
      bus_rsp       <= '0;
    end else begin
      bus_rsp_valid <= 1'b0;
      if (bus_valid && bus_ready) begin
        bus_ready <= 1'b0; // request taken
        cur       <= bus_req;
        sending   <= 1'b1;
        beat_idx  <= 1'b0;
      end else if (sending) begin
        bus_rsp_valid <= 1'b1;
        bus_rsp <= '{data: beat_at(cur.addr + (beat_idx ? 64'd8 : 64'd0)),
                     id: cur.id,
                     last: !cur.burst || beat_idx};
        beat_idx <= 1'b1;
        if (!cur.burst || beat_idx) sending <= 1'b0;
      end else if (bus_valid && !counting) begin
        delay    <= rnd[1:0]; // 0 to 3 extra cycles
        rnd      <= xorshift(rnd);
        counting <= 1'b1;
      end else if (counting) begin
        if (delay == 2'd0) begin
          bus_ready <= 1'b1;
          counting  <= 1'b0;
        end else begin
          delay <= delay - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  localparam addr_t reset_pc   = 64'h8000_0000;
  localparam int    line_count = 16;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       redirect;
  addr_t      redirect_pc;
  logic       fence_i;
  logic       inst_valid;
  logic       inst_ready;
  fetch_rsp_t inst;
  logic       data_valid;
  logic       data_ready;
  bus_req_t   data_req;
  logic       data_rsp_valid;
  bus_rsp_t   data_rsp;
  logic       bus_valid;
  logic       bus_ready;
  bus_req_t   bus_req;
  logic       bus_rsp_valid;
  bus_rsp_t   bus_rsp;

  // stimulus table, one entry per row in each queue
  string row_name[$];
  logic  row_redir[$];
  addr_t row_target[$];
  logic  row_fence[$];
  int    row_count[$];     // 0 means wait for the miss to reach the bus
  logic  row_stall[$];     // random inst_ready
  logic  row_read[$];
  addr_t row_read_addr[$];
  int    row_bus[$];       // 1 bus stays idle, 2 target line read from the bus again

  int          inst_errs  = 0;
  int          data_errs  = 0;
  int          other_errs = 0;
  int          data_beats = 0;
  int          bus_xfers  = 0;
  addr_t       last_bus_addr;
  logic        data_idx;
  logic [31:0] rnd;
  addr_t       data_addr;
  string       data_row;

  fetch_top #(
    .reset_pc   (reset_pc),
    .line_count (line_count)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .fence_i        (fence_i),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst           (inst),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_req       (data_req),
    .data_rsp_valid (data_rsp_valid),
    .data_rsp       (data_rsp),
    .bus_valid      (bus_valid),
    .bus_ready      (bus_ready),
    .bus_req        (bus_req),
    .bus_rsp_valid  (bus_rsp_valid),
    .bus_rsp        (bus_rsp)
  );

  mem_model mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus_valid     (bus_valid),
    .bus_ready     (bus_ready),
    .bus_req       (bus_req),
    .bus_rsp_valid (bus_rsp_valid),
    .bus_rsp       (bus_rsp)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory rule, odd multiply keeps low words distinct
  function automatic inst_t word_at(input addr_t a);
    return (a[31:0] * 32'h9e37_79b1) ^ a[63:32] ^ 32'h3c5a_96e1;
  endfunction

  function automatic beat_t beat_at(input addr_t a);
    return {word_at(a + 64'd4), word_at(a)};
  endfunction

  task automatic add_row(input string name, input logic redir, input addr_t target,
                         input logic fence, input int count, input logic stall,
                         input logic read, input addr_t read_addr, input int bus_rule);
    row_name.push_back(name);
    row_redir.push_back(redir);
    row_target.push_back(target);
    row_fence.push_back(fence);
    row_count.push_back(count);
    row_stall.push_back(stall);
    row_read.push_back(read);
    row_read_addr.push_back(read_addr);
    row_bus.push_back(bus_rule);
  endtask

  // bus traffic counter and data response checker
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_idx      <= 1'b0;
      data_beats    <= 0;
      bus_xfers     <= 0;
      last_bus_addr <= '0;
    end else begin
      if (bus_valid && bus_ready) begin
        bus_xfers     <= bus_xfers + 1;
        last_bus_addr <= bus_req.addr;
      end
      if (data_rsp_valid) begin
        assert (data_rsp.data == beat_at(data_addr + (data_idx ? 64'd8 : 64'd0)) &&
                data_rsp.id == id_data && data_rsp.last == data_idx) else begin
          data_errs++;
          $display("mismatch %s: expected data %h id %0d last %0d, actual data %h id %0d last %0d",
                   data_row, beat_at(data_addr + (data_idx ? 64'd8 : 64'd0)), id_data,
                   data_idx, data_rsp.data, data_rsp.id, data_rsp.last);
        end
        data_idx   <= !data_idx;
        data_beats <= data_beats + 1;
      end
    end
  end

  initial begin
    int    r;
    int    got;
    int    t;
    int    limit;
    int    xfers_mark;
    int    xfers_first;
    int    beats_mark;
    addr_t exp_pc;
    logic  aborted;

    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    fence_i     = 1'b0;
    inst_ready  = 1'b0;
    data_valid  = 1'b0;
    data_req    = '0;
    rnd         = 32'd20;
    data_addr   = '0;
    data_row    = "";
    exp_pc      = reset_pc;
    aborted     = 1'b0;
    beats_mark  = 0;

    add_row("cold_start", 1'b0, '0, 1'b0, 12, 1'b0, 1'b0, '0, 0);
    add_row("warm_hits", 1'b1, reset_pc, 1'b0, 12, 1'b0, 1'b0, '0, 1);
    add_row("miss_start", 1'b1, reset_pc + 64'h200, 1'b0, 0, 1'b0, 1'b0, '0, 0);
    add_row("redirect_in_miss", 1'b1, reset_pc + 64'h300, 1'b0, 4, 1'b0, 1'b0, '0, 0);
    add_row("random_stall", 1'b0, '0, 1'b0, 16, 1'b1, 1'b0, '0, 0);
    add_row("data_read", 1'b1, reset_pc + 64'h400, 1'b0, 8, 1'b0, 1'b1,
            reset_pc + 64'h1000, 0);
    // line still cached from data_read
    add_row("fence_refetch", 1'b1, reset_pc + 64'h400, 1'b1, 4, 1'b0, 1'b0, '0, 2);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (r = 0; r < row_name.size() && !aborted; r++) begin
      if (row_redir[r] || row_fence[r]) begin
        redirect    <= row_redir[r];
        redirect_pc <= row_target[r];
        fence_i     <= row_fence[r];
        @(posedge clk);
        redirect <= 1'b0;
        fence_i  <= 1'b0;
        if (row_redir[r]) exp_pc = row_target[r];
      end
      xfers_mark  = bus_xfers;
      xfers_first = bus_xfers;
      if (row_read[r]) begin
        data_addr  = row_read_addr[r];
        data_row   = row_name[r];
        beats_mark = data_beats;
        data_valid <= 1'b1;
        data_req   <= '{addr: row_read_addr[r], id: 4'd0, burst: 1'b1};
      end

      if (row_count[r] == 0) begin
        t = 0;
        while (bus_xfers == xfers_mark && t < 50) begin
          @(posedge clk);
          t++;
        end
        assert (bus_xfers != xfers_mark) else begin
          other_errs++;
          aborted = 1'b1;
          $display("row %s: the miss never reached the bus", row_name[r]);
        end
      end

      got   = 0;
      t     = 0;
      limit = 60 + 30 * row_count[r];
      while (got < row_count[r] && t < limit) begin
        rnd = xorshift(rnd);
        inst_ready <= row_stall[r] ? rnd[0] : 1'b1;
        @(posedge clk);
        t++;
        if (data_valid && data_ready) data_valid <= 1'b0;
        if (inst_valid && inst_ready) begin
          if (got == 0) xfers_first = bus_xfers;
          assert (inst.pc == exp_pc && inst.instr == word_at(exp_pc)) else begin
            inst_errs++;
            $display("mismatch %s: expected pc %h word %h, actual pc %h word %h",
                     row_name[r], exp_pc, word_at(exp_pc), inst.pc, inst.instr);
          end
          got++;
          exp_pc += 64'd4;
        end
      end
      inst_ready <= 1'b0; // hold the next instruction until the next row
      assert (got == row_count[r]) else begin
        other_errs++;
        aborted = 1'b1;
        $display("row %s timed out after %0d of %0d instructions", row_name[r], got,
                 row_count[r]);
      end

      if (row_read[r] && !aborted) begin
        t = 0;
        while (data_beats < beats_mark + 2 && t < 100) begin
          @(posedge clk);
          t++;
          if (data_valid && data_ready) data_valid <= 1'b0;
        end
        assert (data_beats >= beats_mark + 2) else begin
          other_errs++;
          aborted = 1'b1;
          $display("row %s: the data read did not complete in time", row_name[r]);
        end
      end

      if (row_bus[r] == 1) begin
        assert (bus_xfers == xfers_first) else begin
          other_errs++;
          $display("mismatch %s: expected bus transfers 0, actual %0d", row_name[r],
                   bus_xfers - xfers_first);
        end
      end else if (row_bus[r] == 2) begin
        assert (bus_xfers != xfers_mark &&
                last_bus_addr == {row_target[r][63:4], 4'h0}) else begin
          other_errs++;
          $display("row %s: the invalidated line was not read from the bus again",
                   row_name[r]);
        end
      end
    end

    $display("errors: inst %0d, data %0d, other %0d", inst_errs, data_errs, other_errs);
    if (inst_errs + data_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/icache.sv
logic/mem_arbiter.sv
logic/fetch_top.sv
test/mem_model.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "simulation result: pass"; \
	else \
	  echo "simulation result: no pass line in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
